//--- project.f
+incdir+dv
design/pipePkg.sv
design/hazardUnit.sv
design/regFile.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/pipeCore.sv
dv/pipeCoreTb.sv

//--- Makefile
# Verilator build and run of the pipeline core testbench
# the run target fails when the simulation ends in $fatal

obj_dir/VpipeCoreTb: project.f $(wildcard design/*.sv) dv/pipeCoreTb.sv dv/pipeTests.svh
	verilator --binary --timing --top-module pipeCoreTb -f project.f -o VpipeCoreTb

run: obj_dir/VpipeCoreTb
	./obj_dir/VpipeCoreTb

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- dv/pipeTests.svh
//////////////////////////////////////////////////////////////////////
// test table of the core: instruction encoders, program words and
// the expected retire (rd, value) of each word, per program
//////////////////////////////////////////////////////////////////////
`ifndef pipeTestsSvh
`define pipeTestsSvh

typedef struct packed {
	int wordBase;
	int words;
	int retBase;
	int rets;
	int loads;
	int stores;
} testEntry;

localparam logic [6:0] opcodeImm = 7'b0010011;
localparam logic [6:0] opcodeLoad = 7'b0000011;

logic [31:0] progMem [64];
logic [4:0] retRd [64];
logic [31:0] retVal [64];
testEntry tests [8];
int numWords;
int numRets;
int numTests;

function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
	return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
endfunction

// lw carries funct3 010, addi 000
function automatic logic [31:0] iType(input logic [6:0] op, input int rd, input int rs1,
		input int imm);
	return {imm[11:0], rs1[4:0], (op == opcodeLoad) ? 3'b010 : 3'b000, rd[4:0], op};
endfunction

function automatic logic [31:0] sType(input int rs2, input int rs1, input int imm);
	return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

// beq, offset in bytes from the branch itself
function automatic logic [31:0] bType(input int rs1, input int rs2, input int imm);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jType(input int rd, input int imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

task automatic beginProgram();
	tests[numTests].wordBase = numWords;
	tests[numTests].retBase = numRets;
endtask

// one program word, and the retire it must produce if any
task automatic addRow(input logic [31:0] w, input bit ret, input int rd,
		input logic [31:0] value);
	progMem[numWords] = w;
	numWords++;
	if (ret) begin
		retRd[numRets] = rd[4:0];
		retVal[numRets] = value;
		numRets++;
	end
endtask

task automatic endProgram(input int loads, input int stores);
	tests[numTests].words = numWords - tests[numTests].wordBase;
	tests[numTests].rets = numRets - tests[numTests].retBase;
	tests[numTests].loads = loads;
	tests[numTests].stores = stores;
	numTests++;
endtask

task automatic buildTables();
	numWords = 0;
	numRets = 0;
	numTests = 0;
	// dependent ALU chain, forwarding from memory and writeback
	beginProgram();
	addRow(iType(opcodeImm, 1, 0, 12), 1, 1, 32'd12);
	addRow(iType(opcodeImm, 2, 1, -7), 1, 2, 32'd5);
	addRow(rType(7'h00, 3'b000, 3, 1, 2), 1, 3, 32'd17);
	addRow(rType(7'h20, 3'b000, 4, 3, 1), 1, 4, 32'd5);
	addRow(rType(7'h00, 3'b111, 5, 4, 3), 1, 5, 32'd1);
	addRow(rType(7'h00, 3'b110, 6, 5, 1), 1, 6, 32'd13);
	addRow(rType(7'h20, 3'b000, 7, 0, 6), 1, 7, 32'hfffffff3);
	addRow(rType(7'h00, 3'b000, 8, 7, 3), 1, 8, 32'd4);
	endProgram(0, 0);
	// stores, loads and load-use stalls
	beginProgram();
	addRow(iType(opcodeImm, 1, 0, 40), 1, 1, 32'd40);
	addRow(iType(opcodeImm, 2, 0, 291), 1, 2, 32'd291);
	addRow(sType(2, 1, 8), 0, 0, 32'd0);
	addRow(iType(opcodeLoad, 3, 1, 8), 1, 3, 32'd291);
	addRow(rType(7'h00, 3'b000, 4, 3, 2), 1, 4, 32'd582);
	addRow(sType(4, 1, 12), 0, 0, 32'd0);
	addRow(iType(opcodeLoad, 5, 1, 12), 1, 5, 32'd582);
	addRow(iType(opcodeLoad, 6, 1, 8), 1, 6, 32'd291);
	addRow(rType(7'h20, 3'b000, 7, 6, 5), 1, 7, 32'hfffffedd);
	endProgram(3, 2);
	// taken beq skips two words, the second beq falls through
	beginProgram();
	addRow(iType(opcodeImm, 1, 0, 7), 1, 1, 32'd7);
	addRow(iType(opcodeImm, 2, 0, 7), 1, 2, 32'd7);
	addRow(bType(1, 2, 12), 0, 0, 32'd0);
	addRow(iType(opcodeImm, 3, 0, 1), 0, 0, 32'd0);
	addRow(iType(opcodeImm, 4, 0, 2), 0, 0, 32'd0);
	addRow(iType(opcodeImm, 5, 0, 3), 1, 5, 32'd3);
	addRow(bType(1, 5, 12), 0, 0, 32'd0);
	addRow(iType(opcodeImm, 6, 0, 4), 1, 6, 32'd4);
	addRow(iType(opcodeImm, 7, 0, 5), 1, 7, 32'd5);
	addRow(iType(opcodeImm, 8, 0, 6), 1, 8, 32'd6);
	endProgram(0, 0);
	// jal links pc plus 4 and skips one word
	beginProgram();
	addRow(iType(opcodeImm, 1, 0, 1), 1, 1, 32'd1);
	addRow(jType(2, 8), 1, 2, 32'd8);
	addRow(iType(opcodeImm, 3, 0, 9), 0, 0, 32'd0);
	addRow(rType(7'h00, 3'b000, 4, 2, 1), 1, 4, 32'd9);
	addRow(jType(5, 8), 1, 5, 32'd20);
	addRow(iType(opcodeImm, 6, 0, 1), 0, 0, 32'd0);
	addRow(rType(7'h00, 3'b110, 7, 5, 4), 1, 7, 32'd29);
	endProgram(0, 0);
	// writes to x0 vanish, reads of x0 give zero
	beginProgram();
	addRow(iType(opcodeImm, 0, 0, 5), 0, 0, 32'd0);
	addRow(iType(opcodeImm, 1, 0, 3), 1, 1, 32'd3);
	addRow(rType(7'h00, 3'b000, 0, 1, 1), 0, 0, 32'd0);
	addRow(iType(opcodeImm, 2, 0, 0), 1, 2, 32'd0);
	addRow(rType(7'h20, 3'b000, 4, 1, 0), 1, 4, 32'd3);
	addRow(rType(7'h00, 3'b110, 0, 1, 4), 0, 0, 32'd0);
	addRow(rType(7'h00, 3'b110, 5, 0, 0), 1, 5, 32'd0);
	endProgram(0, 0);
endtask

`endif

//--- dv/pipeCoreTb.sv
//////////////////////////////////////////////////////////////////////
// testbench of the five-stage core: clock, reset, instruction memory
// model, random stall, retire and strobe checks, timeout
//////////////////////////////////////////////////////////////////////
module pipeCoreTb;

	logic clk;
	logic reset;
	logic sysStall;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic memRead;
	logic memWrite;
	logic wbValid;
	logic [4:0] wbRd;
	logic [31:0] wbData;
	int curFirst;
	int curWords;

	`include "pipeTests.svh"

	// jal x0, 0
	localparam logic [31:0] selfLoop = 32'h0000006f;
	// unstalled cycles without a retire before a program counts as done
	localparam int drainCycles = 8;

	pipeCore i_pipeCore (
		.clk, .reset, .sysStall, .imemAddr, .imemData,
		.memRead, .memWrite, .wbValid, .wbRd, .wbData
	);

	always #2 clk = ~clk;

	// past the program the core spins on a self loop
	always_comb begin
		int idx;
		idx = int'(imemAddr[31:2]);
		if (idx < curWords) begin
			imemData = progMem[curFirst + idx];
		end else begin
			imemData = selfLoop;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, want);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic runProgram(input int t, input bit stalls);
		int seen;
		int idle;
		int reads;
		int writes;
		int at;
		seen = 0;
		idle = 0;
		reads = 0;
		writes = 0;
		@(negedge clk);
		sysStall = 1'b0;
		reset = 1'b1;
		curFirst = tests[t].wordBase;
		curWords = tests[t].words;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		while (seen < tests[t].rets || idle < drainCycles) begin
			// outputs settle between edges, sample them before the next stall draw
			@(negedge clk);
			if (!sysStall && memRead) reads++;
			if (!sysStall && memWrite) writes++;
			if (wbValid) begin
				if (seen >= tests[t].rets) begin
					$display("retire of x%0d after the last expected one in program %0d",
						wbRd, t);
					$display("*** FAILED ***");
					$fatal(1, "extra retire");
				end else begin
					at = tests[t].retBase + seen;
					checkValue("wbRd", 32'(wbRd), 32'(retRd[at]));
					checkValue("wbData", wbData, retVal[at]);
					seen++;
				end
			end else if (seen >= tests[t].rets && !sysStall) begin
				idle++;
			end
			sysStall = stalls && ($urandom % 4 == 0);
		end
		sysStall = 1'b0;
		checkValue("memRead cycles", reads, tests[t].loads);
		checkValue("memWrite cycles", writes, tests[t].stores);
	endtask

	// limit covers both passes over the table
	initial begin
		int cycles;
		int limit;
		cycles = 0;
		@(posedge clk);
		limit = 2 * 20 * numWords;
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the programs did not finish within %0d cycles", limit);
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		sysStall = 1'b0;
		curFirst = 0;
		curWords = 0;
		void'($urandom(42664));
		buildTables();
		// second pass repeats every program under random stall
		for (int phase = 0; phase < 2; phase++) begin
			for (int t = 0; t < numTests; t++) begin
				runProgram(t, phase == 1);
			end
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- design/pipeCore.sv
//////////////////////////////////////////////////////////////////////
// five-stage core top: stages, register file and hazard unit
//////////////////////////////////////////////////////////////////////
module pipeCore #(
	parameter logic [31:0] resetPc = 32'h0,
	parameter int memWords = 64
) (
	input logic clk,
	input logic reset,
	input logic sysStall,
	output pipePkg::dataWord imemAddr,
	input pipePkg::dataWord imemData,
	output logic memRead,
	output logic memWrite,
	output logic wbValid,
	output pipePkg::regIdx wbRd,
	output pipePkg::dataWord wbData
);
	import pipePkg::*;

	stageCtrlIf ctrlBus ();
	stageInfoIf infoBus ();

	dataWord instrD, pcD, jalTarget, branchTarget, target;
	logic validD, jalTaken, branchTaken, redirect;
	regIdx rs1, rs2;
	dataWord rd1, rd2;
	aluOp opE;
	dataWord aE, bE, immE, pcE;
	regIdx rdE, rs1E, rs2E;
	logic weE, immSelE, isLoadE, isStoreE, isBranchE, isJalE, validE;
	dataWord aluM, storeM, fwdMemData, fwdWbData;
	regIdx rdM;
	logic weM, isLoadM, isStoreM, validM;

	// beq in execute is older than jal in decode
	assign redirect = branchTaken | jalTaken;
	assign target = branchTaken ? branchTarget : jalTarget;

	fetchStage #(.resetPc(resetPc)) i_fetchStage (
		.clk, .reset, .ctrl(ctrlBus.stage), .redirect, .target,
		.imemAddr, .imemData, .instrD, .pcD, .validD
	);

	decodeStage i_decodeStage (
		.clk, .reset, .instrD, .pcD, .validD, .ctrl(ctrlBus.stage), .info(infoBus.decode),
		.rs1, .rs2, .rd1, .rd2, .jalTaken, .jalTarget,
		.opE, .aE, .bE, .immE, .pcE, .rdE, .rs1E, .rs2E,
		.weE, .immSelE, .isLoadE, .isStoreE, .isBranchE, .isJalE, .validE
	);

	regFile i_regFile (
		.clk, .reset, .rs1, .rs2, .rd1, .rd2,
		.we(wbValid), .rd(wbRd), .wd(wbData)
	);

	executeStage i_executeStage (
		.clk, .reset, .opE, .aE, .bE, .immE, .pcE, .rdE, .rs1E, .rs2E,
		.weE, .immSelE, .isLoadE, .isStoreE, .isBranchE, .isJalE, .validE,
		.ctrl(ctrlBus.stage), .info(infoBus.execute), .fwdMemData, .fwdWbData,
		.branchTaken, .branchTarget,
		.aluM, .storeM, .rdM, .weM, .isLoadM, .isStoreM, .validM
	);

	memWbStage #(.memWords(memWords)) i_memWbStage (
		.clk, .reset, .aluM, .storeM, .rdM, .weM, .isLoadM, .isStoreM, .validM,
		.ctrl(ctrlBus.stage), .info(infoBus.memory), .fwdMemData, .fwdWbData,
		.wbValid, .wbRd, .wbData
	);

	hazardUnit i_hazardUnit (
		.sysStall, .info(infoBus.hazard), .ctrl(ctrlBus.hazard), .memRead, .memWrite
	);

endmodule

//--- design/memWbStage.sv
//////////////////////////////////////////////////////////////////////
// data memory, memory-to-writeback register and retire outputs
//////////////////////////////////////////////////////////////////////
module memWbStage #(
	parameter int memWords = 64
) (
	input logic clk,
	input logic reset,
	input pipePkg::dataWord aluM,
	input pipePkg::dataWord storeM,
	input pipePkg::regIdx rdM,
	input logic weM,
	input logic isLoadM,
	input logic isStoreM,
	input logic validM,
	stageCtrlIf.stage ctrl,
	stageInfoIf.memory info,
	output pipePkg::dataWord fwdMemData,
	output pipePkg::dataWord fwdWbData,
	output logic wbValid,
	output pipePkg::regIdx wbRd,
	output pipePkg::dataWord wbData
);
	import pipePkg::*;

	localparam int addrBits = $clog2(memWords);

	dataWord mem [memWords];
	logic [addrBits-1:0] index;
	dataWord result;
	logic validW;
	logic weW;
	regIdx rdW;
	dataWord dataW;

	// word addressed, byte offset dropped
	assign index = aluM[addrBits+1:2];
	assign result = isLoadM ? mem[index] : aluM;

	always_ff @(posedge clk) begin
		if (validM && isStoreM && !ctrl.holdM) begin
			mem[index] <= storeM;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			validW <= 1'b0;
			weW <= 1'b0;
		end else if (!ctrl.holdW) begin
			validW <= validM;
			weW <= validM & weM;
		end
	end

	always_ff @(posedge clk) begin
		if (!ctrl.holdW) begin
			rdW <= rdM;
			dataW <= result;
		end
	end

	assign info.cmdM = !validM ? cmdOther : isLoadM ? cmdLw : isStoreM ? cmdSw : cmdOther;
	assign info.rdM = rdM;
	assign info.weM = validM & weM;
	assign info.rdW = rdW;
	assign info.weW = validW & weW;

	assign fwdMemData = result;
	assign fwdWbData = dataW;

	// one pulse per retiring write, none while frozen
	assign wbValid = validW & weW & (rdW != '0) & ~ctrl.holdW;
	assign wbRd = rdW;
	assign wbData = dataW;

endmodule

//--- design/executeStage.sv
//////////////////////////////////////////////////////////////////////
// operand forwarding, ALU, beq compare and execute-to-memory register
//////////////////////////////////////////////////////////////////////
module executeStage (
	input logic clk,
	input logic reset,
	input pipePkg::aluOp opE,
	input pipePkg::dataWord aE,
	input pipePkg::dataWord bE,
	input pipePkg::dataWord immE,
	input pipePkg::dataWord pcE,
	input pipePkg::regIdx rdE,
	input pipePkg::regIdx rs1E,
	input pipePkg::regIdx rs2E,
	input logic weE,
	input logic immSelE,
	input logic isLoadE,
	input logic isStoreE,
	input logic isBranchE,
	input logic isJalE,
	input logic validE,
	stageCtrlIf.stage ctrl,
	stageInfoIf.execute info,
	input pipePkg::dataWord fwdMemData,
	input pipePkg::dataWord fwdWbData,
	output logic branchTaken,
	output pipePkg::dataWord branchTarget,
	output pipePkg::dataWord aluM,
	output pipePkg::dataWord storeM,
	output pipePkg::regIdx rdM,
	output logic weM,
	output logic isLoadM,
	output logic isStoreM,
	output logic validM
);
	import pipePkg::*;

	dataWord srcA;
	dataWord srcB;
	dataWord opB;
	dataWord result;

	assign srcA = (ctrl.fwdA == fwdMem) ? fwdMemData : (ctrl.fwdA == fwdWb) ? fwdWbData : aE;
	assign srcB = (ctrl.fwdB == fwdMem) ? fwdMemData : (ctrl.fwdB == fwdWb) ? fwdWbData : bE;
	assign opB = immSelE ? immE : srcB;

	always_comb begin
		case (opE)
			aluSub: result = srcA - opB;
			aluAnd: result = srcA & opB;
			aluOr: result = srcA | opB;
			default: result = srcA + opB;
		endcase
		// jal writes its link address
		if (isJalE) begin
			result = pcE + 32'd4;
		end
	end

	assign branchTaken = validE & isBranchE & (srcA == srcB);
	assign branchTarget = pcE + immE;

	assign info.cmdE = isLoadE ? cmdLw : isStoreE ? cmdSw :
		(isJalE | isBranchE) ? cmdJmp : cmdOther;
	assign info.rdE = rdE;
	assign info.rs1E = rs1E;
	assign info.rs2E = rs2E;
	assign info.takenE = branchTaken;

	always_ff @(posedge clk) begin
		if (reset) begin
			validM <= 1'b0;
			weM <= 1'b0;
			isLoadM <= 1'b0;
			isStoreM <= 1'b0;
		end else if (!ctrl.holdM) begin
			validM <= validE;
			weM <= weE;
			isLoadM <= isLoadE;
			isStoreM <= isStoreE;
		end
	end

	always_ff @(posedge clk) begin
		if (!ctrl.holdM) begin
			aluM <= result;
			storeM <= srcB;
			rdM <= rdE;
		end
	end

endmodule

//--- design/decodeStage.sv
//////////////////////////////////////////////////////////////////////
// decode through the format union, immediates, jal redirect
// and the decode-to-execute register
//////////////////////////////////////////////////////////////////////
module decodeStage (
	input logic clk,
	input logic reset,
	input pipePkg::dataWord instrD,
	input pipePkg::dataWord pcD,
	input logic validD,
	stageCtrlIf.stage ctrl,
	stageInfoIf.decode info,
	output pipePkg::regIdx rs1,
	output pipePkg::regIdx rs2,
	input pipePkg::dataWord rd1,
	input pipePkg::dataWord rd2,
	output logic jalTaken,
	output pipePkg::dataWord jalTarget,
	output pipePkg::aluOp opE,
	output pipePkg::dataWord aE,
	output pipePkg::dataWord bE,
	output pipePkg::dataWord immE,
	output pipePkg::dataWord pcE,
	output pipePkg::regIdx rdE,
	output pipePkg::regIdx rs1E,
	output pipePkg::regIdx rs2E,
	output logic weE,
	output logic immSelE,
	output logic isLoadE,
	output logic isStoreE,
	output logic isBranchE,
	output logic isJalE,
	output logic validE
);
	import pipePkg::*;

	instrWord word;
	logic jalKill;
	logic live;
	logic keep;
	aluOp op;
	dataWord imm;
	regIdx rd;
	logic we;
	logic immSel;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic isJal;

	assign word = instrD;
	// slot right after a jal is wrong path
	assign live = validD & ~jalKill;

	always_comb begin
		op = aluAdd;
		imm = '0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		we = 1'b0;
		immSel = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		if (live) begin
			case (word.r.opcode)
				opOp: begin
					rs1 = word.r.rs1;
					rs2 = word.r.rs2;
					rd = word.r.rd;
					we = 1'b1;
					case (word.r.funct3)
						3'b111: op = aluAnd;
						3'b110: op = aluOr;
						default: op = word.r.funct7[5] ? aluSub : aluAdd;
					endcase
				end
				opOpImm, opLoad: begin
					rs1 = word.i.rs1;
					rd = word.i.rd;
					imm = {{20{word.i.imm[11]}}, word.i.imm};
					immSel = 1'b1;
					we = 1'b1;
					isLoad = (word.i.opcode == opLoad);
				end
				opStore: begin
					rs1 = word.s.rs1;
					rs2 = word.s.rs2;
					imm = {{20{word.s.immHi[6]}}, word.s.immHi, word.s.immLo};
					immSel = 1'b1;
					isStore = 1'b1;
				end
				opBranch: begin
					rs1 = word.b.rs1;
					rs2 = word.b.rs2;
					imm = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
						word.b.imm10to5, word.b.imm4to1, 1'b0};
					isBranch = 1'b1;
				end
				opJal: begin
					rd = word.j.rd;
					imm = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19to12,
						word.j.imm11, word.j.imm10to1, 1'b0};
					we = 1'b1;
					isJal = 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign info.cmdD = isLoad ? cmdLw : isStore ? cmdSw : (isJal | isBranch) ? cmdJmp : cmdOther;
	assign info.rs1D = rs1;
	assign info.rs2D = rs2;

	// a jal on a flushed path must not steer fetch
	assign jalTaken = isJal & ~ctrl.flushD;
	assign jalTarget = pcD + imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			jalKill <= 1'b0;
		end else if (!ctrl.holdD) begin
			jalKill <= jalTaken;
		end
	end

	assign keep = ~(ctrl.bubbleE | ctrl.flushE);

	always_ff @(posedge clk) begin
		if (reset) begin
			validE <= 1'b0;
			weE <= 1'b0;
			immSelE <= 1'b0;
			isLoadE <= 1'b0;
			isStoreE <= 1'b0;
			isBranchE <= 1'b0;
			isJalE <= 1'b0;
		end else if (ctrl.bubbleE || !ctrl.holdE) begin
			validE <= live & keep;
			weE <= we & keep;
			immSelE <= immSel & keep;
			isLoadE <= isLoad & keep;
			isStoreE <= isStore & keep;
			isBranchE <= isBranch & keep;
			isJalE <= isJal & keep;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.bubbleE || !ctrl.holdE) begin
			opE <= op;
			aE <= rd1;
			bE <= rd2;
			immE <= imm;
			pcE <= pcD;
			rdE <= rd;
			rs1E <= rs1;
			rs2E <= rs2;
		end
	end

endmodule

//--- design/fetchStage.sv
//////////////////////////////////////////////////////////////////////
// program counter, redirect and fetch-to-decode register
//////////////////////////////////////////////////////////////////////
module fetchStage #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input logic clk,
	input logic reset,
	stageCtrlIf.stage ctrl,
	input logic redirect,
	input pipePkg::dataWord target,
	output pipePkg::dataWord imemAddr,
	input pipePkg::dataWord imemData,
	output pipePkg::dataWord instrD,
	output pipePkg::dataWord pcD,
	output logic validD
);
	import pipePkg::*;

	dataWord pc;

	assign imemAddr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
		end else if (!ctrl.holdF) begin
			pc <= redirect ? target : pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			validD <= 1'b0;
		end else if (!ctrl.holdD) begin
			validD <= ~ctrl.flushD;
		end
	end

	always_ff @(posedge clk) begin
		if (!ctrl.holdD) begin
			instrD <= imemData;
			pcD <= pc;
		end
	end

endmodule

//--- design/regFile.sv
//////////////////////////////////////////////////////////////////////
// register file, two read ports and one write-through write port
//////////////////////////////////////////////////////////////////////
module regFile (
	input logic clk,
	input logic reset,
	input pipePkg::regIdx rs1,
	input pipePkg::regIdx rs2,
	output pipePkg::dataWord rd1,
	output pipePkg::dataWord rd2,
	input logic we,
	input pipePkg::regIdx rd,
	input pipePkg::dataWord wd
);
	import pipePkg::*;

	dataWord regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 1; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wd;
		end
	end

	// same-cycle write is seen by decode
	assign rd1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

endmodule

//--- design/hazardUnit.sv
//////////////////////////////////////////////////////////////////////
// stage control and stage info interfaces, and the hazard unit:
// forwarding selects, load-use stall, branch flush, system freeze
//////////////////////////////////////////////////////////////////////
interface stageCtrlIf;
	import pipePkg::*;

	logic holdF;
	logic holdD;
	logic holdE;
	logic holdM;
	logic holdW;
	logic flushD;
	logic flushE;
	logic bubbleE;
	fwdSel fwdA;
	fwdSel fwdB;

	modport hazard (
		output holdF, holdD, holdE, holdM, holdW,
		output flushD, flushE, bubbleE, fwdA, fwdB
	);
	modport stage (
		input holdF, holdD, holdE, holdM, holdW,
		input flushD, flushE, bubbleE, fwdA, fwdB
	);
endinterface

interface stageInfoIf;
	import pipePkg::*;

	cmdClass cmdD;
	regIdx rs1D;
	regIdx rs2D;
	cmdClass cmdE;
	regIdx rdE;
	regIdx rs1E;
	regIdx rs2E;
	logic takenE;
	cmdClass cmdM;
	regIdx rdM;
	logic weM;
	regIdx rdW;
	logic weW;

	modport decode (output cmdD, rs1D, rs2D);
	modport execute (output cmdE, rdE, rs1E, rs2E, takenE);
	modport memory (output cmdM, rdM, weM, rdW, weW);
	modport hazard (
		input cmdD, rs1D, rs2D, cmdE, rdE, rs1E, rs2E, takenE,
		input cmdM, rdM, weM, rdW, weW
	);
endinterface

module hazardUnit (
	input logic sysStall,
	stageInfoIf.hazard info,
	stageCtrlIf.hazard ctrl,
	output logic memRead,
	output logic memWrite
);
	import pipePkg::*;

	logic loadUse;

	// memory stage wins over writeback, x0 is never forwarded
	function automatic fwdSel pickSource(input regIdx rs, input regIdx rdM, input logic weM,
			input regIdx rdW, input logic weW);
		fwdSel sel;
		sel = fwdNone;
		if (rs != '0 && rs == rdM && weM) begin
			sel = fwdMem;
		end else if (rs != '0 && rs == rdW && weW) begin
			sel = fwdWb;
		end
		return sel;
	endfunction

	assign loadUse = (info.cmdE == cmdLw) && (info.rdE != '0) &&
		((info.rdE == info.rs1D) || (info.rdE == info.rs2D));

	always_comb begin
		// every stage works
		ctrl.holdF = 1'b0;
		ctrl.holdD = 1'b0;
		ctrl.holdE = 1'b0;
		ctrl.holdM = 1'b0;
		ctrl.holdW = 1'b0;
		ctrl.flushD = 1'b0;
		ctrl.flushE = 1'b0;
		ctrl.bubbleE = 1'b0;
		ctrl.fwdA = pickSource(info.rs1E, info.rdM, info.weM, info.rdW, info.weW);
		ctrl.fwdB = pickSource(info.rs2E, info.rdM, info.weM, info.rdW, info.weW);
		if (sysStall) begin
			// memory system busy, nothing moves
			ctrl.holdF = 1'b1;
			ctrl.holdD = 1'b1;
			ctrl.holdE = 1'b1;
			ctrl.holdM = 1'b1;
			ctrl.holdW = 1'b1;
		end else begin
			if (loadUse) begin
				ctrl.holdF = 1'b1;
				ctrl.holdD = 1'b1;
				ctrl.bubbleE = 1'b1;
			end
			// taken beq kills the two younger slots
			if (info.takenE) begin
				ctrl.flushD = 1'b1;
				ctrl.flushE = 1'b1;
			end
		end
	end

	assign memRead = (info.cmdM == cmdLw);
	assign memWrite = (info.cmdM == cmdSw);

endmodule

//--- design/pipePkg.sv
//////////////////////////////////////////////////////////////////////
// shared types of the five-stage core: widths, command classes,
// ALU operations, forwarding selects, opcodes and instruction formats
//////////////////////////////////////////////////////////////////////
package pipePkg;

	localparam int xlen = 32;
	localparam int regBits = 5;

	typedef logic [xlen-1:0] dataWord;
	typedef logic [regBits-1:0] regIdx;

	// command class seen by the hazard unit
	typedef enum logic [1:0] {
		cmdOther = 2'b00,
		cmdJmp = 2'b01,
		cmdSw = 2'b10,
		cmdLw = 2'b11
	} cmdClass;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr} aluOp;

	typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSel;

	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opOp = 7'b0110011;
	localparam logic [6:0] opOpImm = 7'b0010011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;

	typedef struct packed {
		logic [6:0] funct7;
		regIdx rs2;
		regIdx rs1;
		logic [2:0] funct3;
		regIdx rd;
		logic [6:0] opcode;
	} rFormat;

	typedef struct packed {
		logic [11:0] imm;
		regIdx rs1;
		logic [2:0] funct3;
		regIdx rd;
		logic [6:0] opcode;
	} iFormat;

	typedef struct packed {
		logic [6:0] immHi;
		regIdx rs2;
		regIdx rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFormat;

	// branch offset is scattered, bit 0 implied
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		regIdx rs2;
		regIdx rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		logic [6:0] opcode;
	} bFormat;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		regIdx rd;
		logic [6:0] opcode;
	} jFormat;

	typedef union packed {
		rFormat r;
		iFormat i;
		sFormat s;
		bFormat b;
		jFormat j;
	} instrWord;

endpackage
